//--- files.f
spi_pkg.sv
spi_sclk_gen.sv
spi_xcvr.sv
spi_master.sv
spi_top.sv
tb_clk_gen.sv
spi_slave_model.sv
tb_spi_top.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_spi_top
FILELIST   = files.f
COMMON     = --timing --timescale 1ns/100ps --assert
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS  = --binary -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_spi_top.sv
module tb_spi_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_LIMIT   = 20;   // clocks per bus cycle
  localparam int POLL_LIMIT  = 500;  // status reads per transfer
  localparam int RESET_LIMIT = 50;

  typedef enum logic [1:0] {ROW_RESET, ROW_CTRL, ROW_XFER, ROW_BUSY} row_kind_e;

  typedef struct {
    string              name;
    row_kind_e          kind;
    spi_pkg::spi_conf_t conf;
    spi_pkg::byte_en_t  be;
    spi_pkg::sel_vec_t  selects;
    spi_pkg::spi_byte_t tx;
    logic               wp_n;
    logic               reload;   // preload slave reply first
    spi_pkg::spi_byte_t preload;
    spi_pkg::spi_byte_t exp_rx;
  } row_t;

  logic               clk;
  logic               rst;
  spi_pkg::wb_req_t   wb_req;
  spi_pkg::bus_word_t wb_dat;
  logic               wb_ack;
  logic               miso;
  logic               mosi;
  logic               sclk;
  spi_pkg::sel_vec_t  selects;
  logic               wp_n;
  logic               slave_cpol;
  logic               slave_cpha;
  logic               slave_load;
  spi_pkg::spi_byte_t slave_preload;
  spi_pkg::spi_byte_t slave_captured;

  row_t               rows[$];
  spi_pkg::sel_vec_t  exp_sel;
  spi_pkg::spi_conf_t exp_conf;
  int                 checks;
  int                 errors;
  bit                 timed_out;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  spi_top dut (
    .clk_i     (clk),
    .rst_i     (rst),
    .wb_req_i  (wb_req),
    .wb_dat_o  (wb_dat),
    .wb_ack_o  (wb_ack),
    .miso_i    (miso),
    .mosi_o    (mosi),
    .sclk_o    (sclk),
    .selects_o (selects),
    .wp_n_i    (wp_n)
  );

  spi_slave_model u_slave (
    .ss_n_i     (selects[0]),
    .sclk_i     (sclk),
    .mosi_i     (mosi),
    .cpol_i     (slave_cpol),
    .cpha_i     (slave_cpha),
    .load_i     (slave_load),
    .preload_i  (slave_preload),
    .miso_o     (miso),
    .captured_o (slave_captured)
  );

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  function automatic row_t make_row(string name, row_kind_e kind, logic [7:0] conf,
                                    spi_pkg::byte_en_t be, spi_pkg::sel_vec_t sel,
                                    logic wp_level_n, logic reload);
    row_t r;
    r.name    = name;
    r.kind    = kind;
    r.conf    = spi_pkg::spi_conf_t'(conf);
    r.be      = be;
    r.selects = sel;
    r.tx      = spi_pkg::spi_byte_t'($urandom);
    r.wp_n    = wp_level_n;
    r.reload  = reload;
    r.preload = 8'ha5;
    r.exp_rx  = '0;
    return r;
  endfunction

  task automatic build_table();
    spi_pkg::speed_t    speed;
    spi_pkg::spi_byte_t last_tx;
    last_tx = '0;
    rows.push_back(make_row("reset_values", ROW_RESET, 8'h00, 4'h0, 8'hff, 1'b1, 1'b0));
    rows.push_back(make_row("ctrl_sel_only", ROW_CTRL, 8'h13, 4'b1000, 8'h5a, 1'b1, 1'b0));
    rows.push_back(make_row("ctrl_conf_only", ROW_CTRL, 8'h0e, 4'b0100, 8'h00, 1'b1, 1'b0));
    rows.push_back(make_row("ctrl_both", ROW_CTRL, 8'h07, 4'b1100, 8'hc3, 1'b1, 1'b0));
    rows.push_back(make_row("ctrl_none_wp_low", ROW_CTRL, 8'h1f, 4'b0011, 8'h3c, 1'b0, 1'b0));
    for (int m = 0; m < 8; m++) begin
      speed = (m < 4) ? 3'd0 : 3'd2;
      rows.push_back(make_row($sformatf("xfer_mode%0d_speed%0d", m % 4, speed), ROW_XFER,
                              {3'b000, speed, m[1], m[0]}, 4'b0000, 8'hfe,
                              (m == 5) ? 1'b0 : 1'b1, m == 0));
    end
    rows.push_back(make_row("busy_write", ROW_BUSY, 8'h08, 4'b0000, 8'hfe, 1'b1, 1'b0));
    // reply of each transfer is the byte sent in the one before
    foreach (rows[i]) begin
      if (rows[i].kind inside {ROW_XFER, ROW_BUSY}) begin
        rows[i].exp_rx = rows[i].reload ? rows[i].preload : last_tx;
        last_tx        = rows[i].tx;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // bus access and compares
  //////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic adr, input spi_pkg::byte_en_t be,
                           input spi_pkg::bus_word_t wdat, output spi_pkg::bus_word_t rdat);
    int waited;
    rdat = '0;
    if (timed_out) return;
    @(posedge clk);
    #1 wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: be, dat: wdat};
    waited = 0;
    do begin
      @(posedge clk);
      #1 waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    rdat   = wb_dat;
    wb_req = '0;  // stb drops in the ack cycle
    if (!wb_ack) begin
      timed_out = 1'b1;
      $display("timeout: no bus ack within %0d clocks", ACK_LIMIT);
    end
  endtask

  task automatic bus_write(input logic adr, input spi_pkg::byte_en_t be,
                           input spi_pkg::bus_word_t wdat);
    spi_pkg::bus_word_t unused;
    bus_cycle(1'b1, adr, be, wdat, unused);
  endtask

  task automatic bus_read(input logic adr, output spi_pkg::bus_word_t rdat);
    bus_cycle(1'b0, adr, 4'hf, '0, rdat);
  endtask

  task automatic wait_rx_ready(output spi_pkg::bus_word_t word);
    spi_pkg::spi_status_t st;
    int                   polls;
    polls = 0;
    st    = '0;
    word  = '0;
    while (!timed_out && !st.rx_ready && polls < POLL_LIMIT) begin
      bus_read(spi_pkg::ADR_CTRL, word);
      st = word[2:0];
      polls++;
    end
    if (!st.rx_ready && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: receive-ready not set after %0d status reads", polls);
    end
  endtask

  task automatic check_byte(input string name, input spi_pkg::spi_byte_t exp,
                            input spi_pkg::spi_byte_t act);
    if (timed_out) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input spi_pkg::bus_word_t exp,
                            input spi_pkg::bus_word_t act);
    if (timed_out) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input spi_pkg::spi_status_t exp,
                              input spi_pkg::spi_status_t act);
    if (timed_out) return;
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected wp/busy/ready %03b, actual %03b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // one table row
  //////////////////////////////////////////////////

  task automatic run_row(input row_t r);
    spi_pkg::bus_word_t   word;
    spi_pkg::spi_status_t exp_st;
    @(posedge clk);
    #1 wp_n = r.wp_n;
    exp_st = '{wp: ~r.wp_n, tx_busy: 1'b0, rx_ready: 1'b0};
    case (r.kind)
      ROW_RESET: begin
        bus_read(spi_pkg::ADR_CTRL, word);
        check_byte({r.name, " selects"}, spi_pkg::SEL_RESET, word[31:24]);
        check_byte({r.name, " conf"}, spi_pkg::CONF_RESET, word[23:16]);
        check_status({r.name, " status"}, exp_st, word[2:0]);
        check_byte({r.name, " pins"}, spi_pkg::SEL_RESET, selects);
      end
      ROW_CTRL: begin
        bus_write(spi_pkg::ADR_CTRL, r.be, {r.selects, r.conf, 16'h0000});
        if (r.be[3]) exp_sel = r.selects;
        if (r.be[2]) exp_conf = r.conf;
        bus_read(spi_pkg::ADR_CTRL, word);
        check_word(r.name, {exp_sel, exp_conf, 13'h0000, exp_st}, word);
        check_byte({r.name, " pins"}, exp_sel, selects);
      end
      default: begin
        slave_cpol = r.conf.cpol;
        slave_cpha = r.conf.cpha;
        if (r.reload) begin
          slave_preload = r.preload;
          slave_load    = 1'b1;
          #1 slave_load = 1'b0;
        end
        // mode changes while deselected, then select and launch
        bus_write(spi_pkg::ADR_CTRL, 4'b1100, {spi_pkg::SEL_RESET, r.conf, 16'h0000});
        bus_write(spi_pkg::ADR_CTRL, 4'b1000, {r.selects, 24'h000000});
        bus_write(spi_pkg::ADR_DATA, 4'b0001, spi_pkg::bus_word_t'(r.tx));
        if (r.kind == ROW_BUSY) begin
          bus_write(spi_pkg::ADR_DATA, 4'b0001, {24'h000000, ~r.tx});  // must be dropped
          bus_read(spi_pkg::ADR_CTRL, word);
          exp_st.tx_busy = 1'b1;
          check_status({r.name, " while busy"}, exp_st, word[2:0]);
          exp_st.tx_busy = 1'b0;
        end
        wait_rx_ready(word);
        exp_st.rx_ready = 1'b1;
        check_status({r.name, " done"}, exp_st, word[2:0]);
        bus_read(spi_pkg::ADR_DATA, word);
        check_word({r.name, " rx"}, spi_pkg::bus_word_t'(r.exp_rx), word);
        check_byte({r.name, " slave"}, r.tx, slave_captured);
        bus_read(spi_pkg::ADR_CTRL, word);
        exp_st.rx_ready = 1'b0;
        check_status({r.name, " cleared"}, exp_st, word[2:0]);
        bus_write(spi_pkg::ADR_CTRL, 4'b1000, {spi_pkg::SEL_RESET, 24'h000000});
        exp_sel  = spi_pkg::SEL_RESET;
        exp_conf = r.conf;
      end
    endcase
  endtask

  initial begin
    int waited;
    int errs_before;
    int tests;
    void'($urandom(43341));
    wb_req        = '0;
    wp_n          = 1'b1;
    slave_cpol    = 1'b0;
    slave_cpha    = 1'b0;
    slave_load    = 1'b0;
    slave_preload = '0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    timed_out     = 1'b0;
    exp_sel       = spi_pkg::SEL_RESET;
    exp_conf      = spi_pkg::CONF_RESET;
    build_table();

    waited = 0;
    while (rst !== 1'b0 && waited < RESET_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rst !== 1'b0) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end

    foreach (rows[i]) begin
      if (!timed_out) begin
        errs_before = errors;
        run_row(rows[i]);
        tests++;
        if (timed_out) $display("FAIL %s (timed out)", rows[i].name);
        else if (errors == errs_before) $display("ok   %s", rows[i].name);
        else $display("FAIL %s", rows[i].name);
      end
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- spi_slave_model.sv
module spi_slave_model (
  input  logic               ss_n_i,
  input  logic               sclk_i,
  input  logic               mosi_i,
  input  logic               cpol_i,
  input  logic               cpha_i,
  input  logic               load_i,
  input  spi_pkg::spi_byte_t preload_i,
  output logic               miso_o,
  output spi_pkg::spi_byte_t captured_o
);

  timeunit 1ns;
  timeprecision 100ps;

  spi_pkg::spi_byte_t reply_q;  // byte sent on the next transfer
  spi_pkg::spi_byte_t shout_q;
  spi_pkg::spi_byte_t shin_q;
  int                 bit_cnt;
  logic               sclk_prev;
  logic               ss_prev;
  logic               load_prev;

  initial begin
    reply_q    = '0;
    shout_q    = '0;
    shin_q     = '0;
    captured_o = '0;
    miso_o     = 1'b0;
    bit_cnt    = 0;
    sclk_prev  = sclk_i;
    ss_prev    = 1'b1;
    load_prev  = 1'b0;
    forever begin
      @(sclk_i or ss_n_i or load_i);
      if (load_i && !load_prev) begin
        reply_q = preload_i;
      end
      if (ss_n_i === 1'b0 && ss_prev !== 1'b0) begin
        bit_cnt = 0;
        shout_q = reply_q;
        miso_o  = reply_q[7];  // cpha 0 needs the msb before the first edge
      end else if (ss_n_i === 1'b0 && sclk_i !== sclk_prev) begin
        if ((sclk_i ^ cpol_i) ^ cpha_i) begin  // sample edge
          shin_q  = {shin_q[6:0], mosi_i};
          bit_cnt = bit_cnt + 1;
          if (bit_cnt == spi_pkg::BITS_PER_XFER) begin
            captured_o = shin_q;
            reply_q    = shin_q;  // echoed on the next transfer
          end
        end else if (cpha_i) begin
          miso_o  = shout_q[7];  // drive on leading edge
          shout_q = shout_q << 1;
        end else begin
          shout_q = shout_q << 1;
          miso_o  = shout_q[7];
        end
      end
      sclk_prev = sclk_i;
      ss_prev   = ss_n_i;
      load_prev = load_i;
    end
  end

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1 rst_o = 1'b0;  // released just after the 8th edge
  end

endmodule

//--- spi_top.sv
module spi_top (
  input  logic               clk_i,
  input  logic               rst_i,

  // host bus port
  input  spi_pkg::wb_req_t   wb_req_i,
  output spi_pkg::bus_word_t wb_dat_o,
  output logic               wb_ack_o,

  // SPI pins
  input  logic               miso_i,
  output logic               mosi_o,
  output logic               sclk_o,
  output spi_pkg::sel_vec_t  selects_o,
  input  logic               wp_n_i
);

  //////////////////////////////////////////////////
  // register block with shift engine below
  //////////////////////////////////////////////////

  spi_master u_master (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (wb_req_i),
    .dat_o     (wb_dat_o),
    .ack_o     (wb_ack_o),
    .wp_n_i    (wp_n_i),
    .selects_o (selects_o),
    .miso_i    (miso_i),
    .mosi_o    (mosi_o),
    .sclk_o    (sclk_o)
  );

endmodule

//--- spi_master.sv
module spi_master (
  input  logic                clk_i,
  input  logic                rst_i,
  input  spi_pkg::wb_req_t    req_i,
  output spi_pkg::bus_word_t  dat_o,
  output logic                ack_o,
  input  logic                wp_n_i,
  output spi_pkg::sel_vec_t   selects_o,
  input  logic                miso_i,
  output logic                mosi_o,
  output logic                sclk_o
);

  // reg 0 write: launch transfer with dat[7:0]
  // reg 0 read : received byte, clears rx_ready
  // reg 1 write: sel[3] -> selects, sel[2] -> config byte
  // reg 1 read : {selects, config, 13'b0, wp, tx_busy, rx_ready}

  spi_pkg::bus_state_e  state_q, state_d;
  spi_pkg::sel_vec_t    sel_q, sel_d;
  spi_pkg::spi_conf_t   conf_q, conf_d;
  logic                 tx_busy_q, tx_busy_d;
  logic                 rx_ready_q, rx_ready_d;
  spi_pkg::spi_byte_t   rx_byte_q, rx_byte_d;
  spi_pkg::bus_word_t   dat_q, dat_d;
  spi_pkg::spi_status_t status;
  logic                 xcvr_start;
  logic                 xcvr_done;
  spi_pkg::spi_byte_t   xcvr_rx;

  assign status = '{wp: ~wp_n_i, tx_busy: tx_busy_q, rx_ready: rx_ready_q};

  //////////////////////////////////////////////////
  // bus decode and flags
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    sel_d      = sel_q;
    conf_d     = conf_q;
    tx_busy_d  = tx_busy_q;
    rx_ready_d = rx_ready_q;
    rx_byte_d  = rx_byte_q;
    dat_d      = dat_q;
    xcvr_start = 1'b0;

    case (state_q)
      spi_pkg::BUS_IDLE: begin
        if (req_i.cyc && req_i.stb) begin
          state_d = spi_pkg::BUS_DONE;
          case (req_i.adr)
            spi_pkg::ADR_DATA: begin
              if (req_i.we) begin
                if (!tx_busy_q) begin  // busy write is acked, dropped
                  xcvr_start = 1'b1;
                  tx_busy_d  = 1'b1;
                end
              end else begin
                dat_d      = spi_pkg::bus_word_t'(rx_byte_q);
                rx_ready_d = 1'b0;
              end
            end
            spi_pkg::ADR_CTRL: begin
              if (req_i.we) begin
                if (req_i.sel[3]) begin
                  sel_d = req_i.dat[31:24];
                end
                if (req_i.sel[2]) begin
                  conf_d = spi_pkg::spi_conf_t'(req_i.dat[23:16]);
                end
              end else begin
                dat_d = {sel_q, conf_q, 13'h0000, status};
              end
            end
            default: state_d = spi_pkg::BUS_DONE;
          endcase
        end
      end
      spi_pkg::BUS_DONE: state_d = spi_pkg::BUS_IDLE;  // ack cycle
      default:           state_d = spi_pkg::BUS_IDLE;
    endcase

    // end of transfer wins over a same-cycle data read
    if (xcvr_done && tx_busy_q) begin
      rx_byte_d  = xcvr_rx;
      tx_busy_d  = 1'b0;
      rx_ready_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= spi_pkg::BUS_IDLE;
      sel_q      <= spi_pkg::SEL_RESET;
      conf_q     <= spi_pkg::CONF_RESET;
      tx_busy_q  <= 1'b0;
      rx_ready_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      sel_q      <= sel_d;
      conf_q     <= conf_d;
      tx_busy_q  <= tx_busy_d;
      rx_ready_q <= rx_ready_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rx_byte_q <= rx_byte_d;
    dat_q     <= dat_d;
  end

  assign ack_o     = (state_q == spi_pkg::BUS_DONE);
  assign dat_o     = dat_q;  // holds until next read
  assign selects_o = sel_q;

  spi_xcvr u_xcvr (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (xcvr_start),
    .tx_i    (req_i.dat[7:0]),
    .conf_i  (conf_q),
    .miso_i  (miso_i),
    .mosi_o  (mosi_o),
    .sclk_o  (sclk_o),
    .rx_o    (xcvr_rx),
    .done_o  (xcvr_done)
  );

  a_ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o
  );

endmodule

//--- spi_xcvr.sv
module spi_xcvr (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  spi_pkg::spi_byte_t tx_i,
  input  spi_pkg::spi_conf_t conf_i,
  input  logic               miso_i,
  output logic               mosi_o,
  output logic               sclk_o,
  output spi_pkg::spi_byte_t rx_o,
  output logic               done_o
);

  spi_pkg::xcvr_state_e          state_q;
  spi_pkg::spi_conf_t            conf_q;
  spi_pkg::spi_byte_t            shreg_q;   // tx bits out the top, rx bits in the bottom
  logic [spi_pkg::BIT_CNT_W-1:0] bit_cnt_q; // samples taken so far
  logic                          mosi_q;
  logic                          run;
  logic                          lead;
  logic                          trail;
  logic                          sample_stb;
  logic                          shift_stb;
  logic                          last_edge;

  assign run        = (state_q == spi_pkg::XCVR_SHIFT);
  assign sample_stb = conf_q.cpha ? trail : lead;
  assign shift_stb  = conf_q.cpha ? lead : trail;

  // transfer ends on the trailing edge that carries or follows the 8th sample
  assign last_edge = trail &&
    ((bit_cnt_q + spi_pkg::BIT_CNT_W'(sample_stb)) ==
     spi_pkg::BIT_CNT_W'(spi_pkg::BITS_PER_XFER));

  spi_sclk_gen u_sclk_gen (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .run_i   (run),
    .speed_i (conf_q.speed),
    .cpol_i  (conf_q.cpol),
    .sclk_o  (sclk_o),
    .lead_o  (lead),
    .trail_o (trail)
  );

  //////////////////////////////////////////////////
  // transfer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= spi_pkg::XCVR_IDLE;
      conf_q    <= spi_pkg::CONF_RESET;
      bit_cnt_q <= '0;
      mosi_q    <= 1'b0;
    end else begin
      case (state_q)
        spi_pkg::XCVR_IDLE: begin
          conf_q <= conf_i;  // tracks register so sclk idles at current cpol
          if (start_i) begin
            bit_cnt_q <= '0;
            if (!conf_i.cpha) begin
              mosi_q <= tx_i[7];  // first bit ahead of first edge
            end
            state_q <= spi_pkg::XCVR_SHIFT;
          end
        end
        spi_pkg::XCVR_SHIFT: begin
          if (sample_stb) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
          if (shift_stb && !last_edge) begin
            mosi_q <= shreg_q[7];  // next bit, msb first
          end
          if (last_edge) begin
            state_q <= spi_pkg::XCVR_FINISH;
          end
        end
        spi_pkg::XCVR_FINISH: state_q <= spi_pkg::XCVR_IDLE;  // one-cycle done
        default:              state_q <= spi_pkg::XCVR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == spi_pkg::XCVR_IDLE) && start_i) begin
      shreg_q <= tx_i;
    end else if (run && sample_stb) begin
      shreg_q <= {shreg_q[6:0], miso_i};
    end
  end

  assign mosi_o = mosi_q;
  assign rx_o   = shreg_q;  // full byte once in FINISH
  assign done_o = (state_q == spi_pkg::XCVR_FINISH);

  // register block must hold off start while a transfer runs
  a_start_in_idle: assert property (
    @(posedge clk_i) disable iff (rst_i) start_i |-> (state_q == spi_pkg::XCVR_IDLE)
  );

  a_done_single: assert property (
    @(posedge clk_i) disable iff (rst_i) done_o |=> !done_o
  );

endmodule

//--- spi_sclk_gen.sv
module spi_sclk_gen (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            run_i,
  input  spi_pkg::speed_t speed_i,
  input  logic            cpol_i,
  output logic            sclk_o,
  output logic            lead_o,
  output logic            trail_o
);

  logic [spi_pkg::HALF_CNT_W-1:0] cnt_q;
  logic [spi_pkg::HALF_CNT_W-1:0] term;
  logic                           phase_q;  // 1 while sclk sits at the active level
  logic                           tick;

  // terminal count is 2**speed - 1
  assign term = {spi_pkg::HALF_CNT_W{1'b1}} >> (spi_pkg::HALF_CNT_W - speed_i);
  assign tick = run_i && (cnt_q == term);

  //////////////////////////////////////////////////
  // half-period counter and phase
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
    end else if (!run_i) begin
      cnt_q   <= '0;     // restart cleanly for next transfer
      phase_q <= 1'b0;   // back to idle level
    end else if (tick) begin
      cnt_q   <= '0;
      phase_q <= ~phase_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign sclk_o  = phase_q ^ cpol_i;  // idle level equals cpol
  assign lead_o  = tick && !phase_q;  // next edge leaves idle
  assign trail_o = tick && phase_q;   // next edge returns to idle

  // each transfer starts with sclk at its idle level
  a_idle_at_start: assert property (
    @(posedge clk_i) disable iff (rst_i) (run_i && !$past(run_i)) |-> (sclk_o == cpol_i)
  );

endmodule

//--- spi_pkg.sv
package spi_pkg;

  //////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////

  typedef logic [7:0]  spi_byte_t;   // one serial data byte
  typedef logic [31:0] bus_word_t;   // bus data word
  typedef logic [3:0]  byte_en_t;    // bus byte enables
  typedef logic [7:0]  sel_vec_t;    // chip selects, active low

  localparam int SPEED_W = 3;
  typedef logic [SPEED_W-1:0] speed_t;  // half-period = 2**speed clocks

  localparam int HALF_CNT_W    = (1 << SPEED_W) - 1;  // counts up to 127
  localparam int BITS_PER_XFER = 8;
  localparam int BIT_CNT_W     = 4;                   // holds 0..8

  //////////////////////////////////////////////////
  // structs and state encodings
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [2:0] rsvd;
    speed_t     speed;
    logic       cpol;
    logic       cpha;
  } spi_conf_t;

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    logic      adr;
    byte_en_t  sel;
    bus_word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic wp;        // inverted wp_n pin
    logic tx_busy;
    logic rx_ready;
  } spi_status_t;

  typedef enum logic {BUS_IDLE, BUS_DONE} bus_state_e;
  typedef enum logic [1:0] {XCVR_IDLE, XCVR_SHIFT, XCVR_FINISH} xcvr_state_e;

  localparam sel_vec_t  SEL_RESET  = 8'hff;  // nothing selected
  localparam spi_conf_t CONF_RESET = '0;     // mode 0, fastest
  localparam logic      ADR_DATA   = 1'b0;
  localparam logic      ADR_CTRL   = 1'b1;

endpackage
